// ==== design/usb_bridge_pkg.sv ====
`default_nettype none

package usb_bridge_pkg;

   // widths with a meaning on the register bus
   typedef logic [31:0] bus_data_t;   // one register word
   typedef logic [3:0]  bus_addr_t;   // byte address inside the bridge

   // payload types toward the function cores
   typedef logic [7:0]         byte_t;     // serial byte
   typedef logic signed [15:0] sample_t;   // one audio channel
   typedef logic [15:0]        key_t;      // keyboard usage value
   typedef logic [3:0]         pad_t;      // pad control bundle of one core

   // bit positions inside pad_t
   localparam int PAD_PULL = 0;   // D+ pull-up
   localparam int PAD_OE   = 1;   // output enable
   localparam int PAD_DP   = 2;   // D+ drive
   localparam int PAD_DN   = 3;   // D- drive

   // function codes as written into CCR bits 2:0
   typedef enum logic [2:0] {
      FUNC_NONE   = 3'd0,
      FUNC_AUDIO  = 3'd1,
      FUNC_KEY    = 3'd4,
      FUNC_SERIAL = 3'd5
   } func_e;

   // register byte offsets
   localparam bus_addr_t REG_CCR = 4'd0;
   localparam bus_addr_t REG_RDR = 4'd4;
   localparam bus_addr_t REG_TDR = 4'd8;
   localparam bus_addr_t REG_STA = 4'd12;

   // status register bits
   localparam int STA_TX_BUSY  = 0;
   localparam int STA_RX_AVAIL = 1;
   localparam int STA_RX_OVF   = 2;

   // serial receive fifo, depth kept a power of two so pointers wrap
   localparam int RX_FIFO_DEPTH = 4;
   localparam int RX_PTR_W      = $clog2(RX_FIFO_DEPTH);
   localparam int RX_CNT_W      = RX_PTR_W + 1;   // count reaches depth itself

endpackage

`default_nettype wire

// ==== design/usb_rx_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module usb_rx_fifo (
   input  wire                       clk_i,
   input  wire                       rst_i,
   input  wire                       push_i,
   input  wire  usb_bridge_pkg::byte_t    data_i,
   input  wire                       pop_i,
   output usb_bridge_pkg::byte_t     head_o,
   output logic                      empty_o,
   output logic                      ovf_o
);
   import usb_bridge_pkg::*;

   byte_t               mem_q [RX_FIFO_DEPTH];
   logic [RX_PTR_W-1:0] rd_ptr_q;
   logic [RX_PTR_W-1:0] wr_ptr_q;
   logic [RX_CNT_W-1:0] count_q;
   logic                full;
   logic                do_push;
   logic                do_pop;

   assign empty_o = (count_q == '0);
   assign full    = (count_q == RX_CNT_W'(RX_FIFO_DEPTH));

   assign do_pop  = pop_i && !empty_o;              // pop on empty ignored
   assign do_push = push_i && (!full || do_pop);    // a pop frees room on the same edge
   assign ovf_o   = push_i && !do_push;             // byte lost

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at depth
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         count_q <= count_q + RX_CNT_W'(do_push) - RX_CNT_W'(do_pop);
      end
   end

   // storage
   always_ff @(posedge clk_i) begin
      if (do_push)
         mem_q[wr_ptr_q] <= data_i;
   end

   assign head_o = mem_q[rd_ptr_q];   // first-word fall-through

   a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
      count_q <= RX_CNT_W'(RX_FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== design/usb_func_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module usb_func_ctrl (
   input  wire                        clk_i,
   input  wire                        rst_i,
   input  wire  usb_bridge_pkg::func_e     ccr_func_i,
   input  wire                        tx_busy_i,
   input  wire  usb_bridge_pkg::pad_t      pad_audio_i,
   input  wire  usb_bridge_pkg::pad_t      pad_key_i,
   input  wire  usb_bridge_pkg::pad_t      pad_serial_i,
   input  wire                        send_ready_i,
   input  wire                        audio_en_i,
   output usb_bridge_pkg::func_e      func_sel_o,
   output logic                       audio_rst_o,
   output logic                       key_rst_o,
   output logic                       serial_rst_o,
   output logic                       usb_dp_pull_o,
   output logic                       usb_oe_o,
   output logic                       usb_dp_tx_o,
   output logic                       usb_dn_tx_o,
   output logic                       send_valid_o,
   output logic                       key_request_o,
   output logic                       tx_done_o,
   output logic                       audio_capture_o
);
   import usb_bridge_pkg::*;

   func_e func_q;      // the function currently in charge
   pad_t  pad_sel;     // routed pad bundle
   logic  key_req_q;   // one cycle key press toward the keyboard core
   logic  key_sel;
   logic  send_fire;   // serial byte handed over this cycle

   assign key_sel = (func_q == FUNC_KEY);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         func_q    <= FUNC_NONE;
         key_req_q <= 1'b0;
      end else begin
         func_q    <= ccr_func_i;   // follows CCR one edge later
         // fire once per TDR, and not while the selection is moving away
         key_req_q <= key_sel && (ccr_func_i == FUNC_KEY) && tx_busy_i && !key_req_q;
      end
   end

   // every core except the selected one is held in reset
   assign audio_rst_o  = rst_i || (func_q != FUNC_AUDIO);
   assign key_rst_o    = rst_i || (func_q != FUNC_KEY);
   assign serial_rst_o = rst_i || (func_q != FUNC_SERIAL);

   always_comb begin
      case (func_q)
         FUNC_AUDIO:  pad_sel = pad_audio_i;
         FUNC_KEY:    pad_sel = pad_key_i;
         FUNC_SERIAL: pad_sel = pad_serial_i;
         default:     pad_sel = '0;   // nothing selected, bus released
      endcase
   end

   assign usb_dp_pull_o = pad_sel[PAD_PULL];
   assign usb_oe_o      = pad_sel[PAD_OE];
   assign usb_dp_tx_o   = pad_sel[PAD_DP];
   assign usb_dn_tx_o   = pad_sel[PAD_DN];

   // serial transmit handshake
   assign send_valid_o = (func_q == FUNC_SERIAL) && tx_busy_i;
   assign send_fire    = send_valid_o && send_ready_i;

   assign key_request_o = key_req_q;
   assign tx_done_o     = send_fire || key_req_q;   // either one retires TDR

   // audio strobes only count for the active audio core
   assign audio_capture_o = audio_en_i && (func_q == FUNC_AUDIO);

   assign func_sel_o = func_q;

   // never two cores out of reset together
   a_one_core_live: assert property (@(posedge clk_i)
      $onehot0({!audio_rst_o, !key_rst_o, !serial_rst_o}));

   a_key_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
      key_request_o |=> !key_request_o);

   // valid holds through back-pressure while the selection stays put
   a_send_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      send_valid_o && !send_ready_i && (ccr_func_i == func_q) |=> send_valid_o);

endmodule

`default_nettype wire

// ==== design/usb_reg_bank.sv ====
`timescale 1ns/10ps
`default_nettype none

module usb_reg_bank (
   input  wire                        clk_i,
   input  wire                        rst_i,
   input  wire                        write_i,
   input  wire  [3:0]                 be_i,
   input  wire  usb_bridge_pkg::bus_addr_t addr_i,
   input  wire  usb_bridge_pkg::bus_data_t wdata_i,
   input  wire  usb_bridge_pkg::func_e     func_sel_i,
   input  wire                        tx_done_i,
   input  wire                        audio_capture_i,
   input  wire  usb_bridge_pkg::sample_t   audio_li_i,
   input  wire  usb_bridge_pkg::sample_t   audio_ri_i,
   input  wire  usb_bridge_pkg::byte_t     fifo_head_i,
   input  wire                        fifo_empty_i,
   input  wire                        fifo_ovf_i,
   output usb_bridge_pkg::bus_data_t  rdata_o,
   output usb_bridge_pkg::func_e      ccr_func_o,
   output logic                       tx_busy_o,
   output usb_bridge_pkg::bus_data_t  tdr_o,
   output logic                       fifo_pop_o
);
   import usb_bridge_pkg::*;

   logic [2:0] ccr_code_q;     // raw function code
   bus_data_t  tdr_q;
   bus_data_t  rdr_audio_q;    // left in 31:16, right in 15:0
   logic       audio_flag_q;   // new audio capture waiting
   logic       tx_busy_q;
   logic       ovf_q;          // sticky receive overflow
   logic       wr_ccr;
   logic       wr_tdr;
   logic       wr_sta;
   logic       tdr_accept;
   logic       clr_avail;
   logic       clr_ovf;
   logic       serial_sel;
   logic       tx_owner;       // a function that drains TDR is selected
   logic       rx_avail;

   assign wr_ccr = write_i && (addr_i == REG_CCR);
   assign wr_tdr = write_i && (addr_i == REG_TDR);
   assign wr_sta = write_i && (addr_i == REG_STA) && be_i[0];   // status bits live in byte 0

   assign serial_sel = (func_sel_i == FUNC_SERIAL);
   assign tx_owner   = serial_sel || (func_sel_i == FUNC_KEY);
   assign tdr_accept = wr_tdr && !tx_busy_q;   // writes while busy are dropped
   assign clr_avail  = wr_sta && wdata_i[STA_RX_AVAIL];
   assign clr_ovf    = wr_sta && wdata_i[STA_RX_OVF];

   assign fifo_pop_o = clr_avail && serial_sel;   // w1c on RX_AVAIL pops the head
   assign rx_avail   = serial_sel ? !fifo_empty_i : audio_flag_q;

   // code to function, unused codes select nothing
   always_comb begin
      case (ccr_code_q)
         3'd1:    ccr_func_o = FUNC_AUDIO;
         3'd4:    ccr_func_o = FUNC_KEY;
         3'd5:    ccr_func_o = FUNC_SERIAL;
         default: ccr_func_o = FUNC_NONE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ccr_code_q   <= 3'd0;
         tdr_q        <= '0;
         rdr_audio_q  <= '0;
         audio_flag_q <= 1'b0;
         tx_busy_q    <= 1'b0;
         ovf_q        <= 1'b0;
      end else begin
         if (wr_ccr && be_i[0])
            ccr_code_q <= wdata_i[2:0];

         if (tdr_accept) begin
            for (int b = 0; b < 4; b++) begin
               if (be_i[b])
                  tdr_q[8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end

         // busy only means something while serial or keyboard consumes TDR
         if (!tx_owner || tx_done_i)
            tx_busy_q <= 1'b0;
         else if (tdr_accept)
            tx_busy_q <= 1'b1;

         if (audio_capture_i) begin
            rdr_audio_q  <= {audio_li_i, audio_ri_i};
            audio_flag_q <= 1'b1;   // fresh sample wins over a clear
         end else if (clr_avail && (func_sel_i == FUNC_AUDIO)) begin
            audio_flag_q <= 1'b0;
         end

         if (fifo_ovf_i)
            ovf_q <= 1'b1;
         else if (clr_ovf)
            ovf_q <= 1'b0;
      end
   end

   // read mux
   always_comb begin
      case (addr_i)
         REG_CCR: rdata_o = {29'd0, ccr_code_q};
         REG_RDR: begin
            if (serial_sel)
               rdata_o = fifo_empty_i ? '0 : {24'd0, fifo_head_i};
            else
               rdata_o = rdr_audio_q;
         end
         REG_TDR: rdata_o = tdr_q;
         REG_STA: rdata_o = {29'd0, ovf_q, rx_avail, tx_busy_q};
         default: rdata_o = '0;
      endcase
   end

   assign tx_busy_o = tx_busy_q;
   assign tdr_o     = tdr_q;

   // completion from the control side only answers an outstanding TDR
   a_done_needs_busy: assert property (@(posedge clk_i) disable iff (rst_i)
      tx_done_i |-> tx_busy_q);

endmodule

`default_nettype wire

// ==== design/usb_bridge_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module usb_bridge_top (
   input  wire                        clk_i,
   input  wire                        rst_i,
   // register bus
   input  wire                        write_i,
   input  wire  [3:0]                 be_i,
   input  wire  usb_bridge_pkg::bus_addr_t addr_i,
   input  wire  usb_bridge_pkg::bus_data_t wdata_i,
   output usb_bridge_pkg::bus_data_t  rdata_o,
   // pads from each core
   input  wire  usb_bridge_pkg::pad_t      pad_audio_i,
   input  wire  usb_bridge_pkg::pad_t      pad_key_i,
   input  wire  usb_bridge_pkg::pad_t      pad_serial_i,
   // per core resets, active high
   output logic                       audio_rst_o,
   output logic                       key_rst_o,
   output logic                       serial_rst_o,
   // routed pads toward the board buffer
   output logic                       usb_dp_pull_o,
   output logic                       usb_oe_o,
   output logic                       usb_dp_tx_o,
   output logic                       usb_dn_tx_o,
   // serial core
   input  wire  usb_bridge_pkg::byte_t     recv_data_i,
   input  wire                        recv_valid_i,
   output usb_bridge_pkg::byte_t      send_data_o,
   output logic                       send_valid_o,
   input  wire                        send_ready_i,
   // audio core
   input  wire                        audio_en_i,
   input  wire  usb_bridge_pkg::sample_t   audio_li_i,
   input  wire  usb_bridge_pkg::sample_t   audio_ri_i,
   output usb_bridge_pkg::sample_t    audio_lo_o,
   output usb_bridge_pkg::sample_t    audio_ro_o,
   // keyboard core
   output usb_bridge_pkg::key_t       key_value_o,
   output logic                       key_request_o
);
   import usb_bridge_pkg::*;

   func_e     ccr_func;       // requested by the CPU
   func_e     func_sel;       // in effect
   logic      tx_busy;
   logic      tx_done;
   logic      audio_capture;
   bus_data_t tdr;
   byte_t     fifo_head;
   logic      fifo_empty;
   logic      fifo_ovf;
   logic      fifo_pop;
   logic      fifo_push;

   assign fifo_push = recv_valid_i && (func_sel == FUNC_SERIAL);

   // TDR fans out to every transmit path
   assign send_data_o = tdr[7:0];
   assign key_value_o = tdr[15:0];
   assign audio_lo_o  = tdr[31:16];
   assign audio_ro_o  = tdr[15:0];

   usb_func_ctrl ctrl_i (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .ccr_func_i      (ccr_func),
      .tx_busy_i       (tx_busy),
      .pad_audio_i     (pad_audio_i),
      .pad_key_i       (pad_key_i),
      .pad_serial_i    (pad_serial_i),
      .send_ready_i    (send_ready_i),
      .audio_en_i      (audio_en_i),
      .func_sel_o      (func_sel),
      .audio_rst_o     (audio_rst_o),
      .key_rst_o       (key_rst_o),
      .serial_rst_o    (serial_rst_o),
      .usb_dp_pull_o   (usb_dp_pull_o),
      .usb_oe_o        (usb_oe_o),
      .usb_dp_tx_o     (usb_dp_tx_o),
      .usb_dn_tx_o     (usb_dn_tx_o),
      .send_valid_o    (send_valid_o),
      .key_request_o   (key_request_o),
      .tx_done_o       (tx_done),
      .audio_capture_o (audio_capture)
   );

   usb_reg_bank regs_i (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .write_i         (write_i),
      .be_i            (be_i),
      .addr_i          (addr_i),
      .wdata_i         (wdata_i),
      .func_sel_i      (func_sel),
      .tx_done_i       (tx_done),
      .audio_capture_i (audio_capture),
      .audio_li_i      (audio_li_i),
      .audio_ri_i      (audio_ri_i),
      .fifo_head_i     (fifo_head),
      .fifo_empty_i    (fifo_empty),
      .fifo_ovf_i      (fifo_ovf),
      .rdata_o         (rdata_o),
      .ccr_func_o      (ccr_func),
      .tx_busy_o       (tx_busy),
      .tdr_o           (tdr),
      .fifo_pop_o      (fifo_pop)
   );

   // flushed whenever the serial core sits in reset
   usb_rx_fifo rx_fifo_i (
      .clk_i   (clk_i),
      .rst_i   (serial_rst_o),
      .push_i  (fifo_push),
      .data_i  (recv_data_i),
      .pop_i   (fifo_pop),
      .head_o  (fifo_head),
      .empty_o (fifo_empty),
      .ovf_o   (fifo_ovf)
   );

endmodule

`default_nettype wire

// ==== bench/usb_bridge_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module usb_bridge_tb;
   import usb_bridge_pkg::*;

   localparam int CLK_PERIOD  = 20;
   localparam int TEST_CYCLES = 40 + 120 + 80 + 160 + 80 + 80;   // reset, select, tx, rx, audio, key

   logic       clk_i = 1'b0;
   logic       rst_i;
   logic       write_i;
   logic [3:0] be_i;
   bus_addr_t  addr_i;
   bus_data_t  wdata_i;
   bus_data_t  rdata_o;
   pad_t       pad_audio_i;
   pad_t       pad_key_i;
   pad_t       pad_serial_i;
   logic       audio_rst_o;
   logic       key_rst_o;
   logic       serial_rst_o;
   logic       usb_dp_pull_o;
   logic       usb_oe_o;
   logic       usb_dp_tx_o;
   logic       usb_dn_tx_o;
   byte_t      recv_data_i;
   logic       recv_valid_i;
   byte_t      send_data_o;
   logic       send_valid_o;
   logic       send_ready_i;
   logic       audio_en_i;
   sample_t    audio_li_i;
   sample_t    audio_ri_i;
   sample_t    audio_lo_o;
   sample_t    audio_ro_o;
   key_t       key_value_o;
   logic       key_request_o;

   // model of the bridge as the CPU should see it
   logic [2:0] m_code = '0;
   func_e      m_func = FUNC_NONE;
   bus_data_t  m_tdr = '0;
   bus_data_t  m_audio = '0;      // left in 31:16
   logic       m_flag = 1'b0;
   logic       m_busy = 1'b0;
   logic       m_ovf = 1'b0;
   byte_t      fifo_model[$];
   byte_t      sent_q[$];         // bytes taken by the serial core model
   int         key_count = 0;
   key_t       key_last = '0;
   int         n_checks = 0;
   int         n_val_err = 0;
   int         n_other_err = 0;

   usb_bridge_top dut_i (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   // serial core model takes the byte when valid and ready meet before the next edge
   always @(negedge clk_i) begin
      if (!rst_i && send_valid_o && send_ready_i)
         sent_q.push_back(send_data_o);
   end

   // keyboard core counts key presses
   always @(negedge clk_i) begin
      if (!rst_i && key_request_o) begin
         key_count = key_count + 1;
         key_last  = key_value_o;
      end
   end

   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      $display("timeout, tests still running after %0d cycles", 2 * TEST_CYCLES);
      $display("=== FAIL ===");
      $finish;
   end

   function automatic func_e code_to_func(input logic [2:0] c);
      case (c)
         3'd1:    return FUNC_AUDIO;
         3'd4:    return FUNC_KEY;
         3'd5:    return FUNC_SERIAL;
         default: return FUNC_NONE;   // 2, 3, 6, 7 and 0
      endcase
   endfunction

   function automatic pad_t exp_pad(input pad_t pa, input pad_t pk, input pad_t ps);
      case (m_func)
         FUNC_AUDIO:  return pa;
         FUNC_KEY:    return pk;
         FUNC_SERIAL: return ps;
         default:     return '0;
      endcase
   endfunction

   // expected read value of one register
   function automatic bus_data_t ref_reg(input bus_addr_t a);
      bus_data_t v;
      logic      avail;
      v     = '0;
      avail = (m_func == FUNC_SERIAL) ? (fifo_model.size() != 0) : m_flag;
      case (a)
         REG_CCR: v = {29'd0, m_code};
         REG_RDR: begin
            if (m_func == FUNC_SERIAL)
               v = (fifo_model.size() == 0) ? '0 : {24'd0, fifo_model[0]};
            else
               v = m_audio;
         end
         REG_TDR: v = m_tdr;
         REG_STA: v = {29'd0, m_ovf, avail, m_busy};
         default: v = '0;
      endcase
      return v;
   endfunction

   function automatic void apply_write(input bus_addr_t a, input bus_data_t d,
                                       input logic [3:0] be);
      if (a == REG_CCR && be[0])
         m_code = d[2:0];
      if (a == REG_TDR && !m_busy) begin   // dropped while busy
         for (int b = 0; b < 4; b++)
            if (be[b])
               m_tdr[8*b +: 8] = d[8*b +: 8];
         m_busy = (m_func == FUNC_SERIAL) || (m_func == FUNC_KEY);
      end
      if (a == REG_STA && be[0]) begin
         if (d[STA_RX_AVAIL] && m_func == FUNC_SERIAL && fifo_model.size() != 0)
            void'(fifo_model.pop_front());
         else if (d[STA_RX_AVAIL] && m_func == FUNC_AUDIO)
            m_flag = 1'b0;
         if (d[STA_RX_OVF])
            m_ovf = 1'b0;
      end
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_val_err++;
         $display("FAIL %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic note_error(input string msg);
      n_other_err++;
      $display("ERROR %s at %0t", msg, $time);
   endtask

   task automatic bus_write(input bus_addr_t a, input bus_data_t d, input logic [3:0] be);
      @(posedge clk_i);
      write_i <= 1'b1;
      addr_i  <= a;
      wdata_i <= d;
      be_i    <= be;
      @(posedge clk_i);   // write lands on this edge
      write_i <= 1'b0;
      apply_write(a, d, be);
   endtask

   task automatic read_check(input bus_addr_t a);
      @(posedge clk_i);
      addr_i <= a;
      @(negedge clk_i);
      check($sformatf("rdata_o@0x%0h", a), rdata_o, ref_reg(a));
   endtask

   task automatic select_func(input int code);
      pad_t pa;
      pad_t pk;
      pad_t ps;
      pa = 4'($urandom);
      pk = 4'($urandom);
      ps = 4'($urandom);
      @(posedge clk_i);
      pad_audio_i  <= pa;
      pad_key_i    <= pk;
      pad_serial_i <= ps;
      bus_write(REG_CCR, 32'(code), 4'h1);
      @(posedge clk_i);   // control state takes the code here
      m_func = code_to_func(3'(code));
      if (m_func != FUNC_SERIAL)
         fifo_model.delete();   // fifo flushed with the serial core in reset
      if (m_func != FUNC_SERIAL && m_func != FUNC_KEY)
         m_busy = 1'b0;
      @(negedge clk_i);
      check("audio/key/serial_rst_o", {29'd0, audio_rst_o, key_rst_o, serial_rst_o},
            {29'd0, m_func != FUNC_AUDIO, m_func != FUNC_KEY, m_func != FUNC_SERIAL});
      check("usb pads dn/dp/oe/pull", {28'd0, usb_dn_tx_o, usb_dp_tx_o, usb_oe_o, usb_dp_pull_o},
            {28'd0, exp_pad(pa, pk, ps)});
      read_check(REG_CCR);
   endtask

   task automatic push_byte(input byte_t b);
      @(posedge clk_i);
      recv_valid_i <= 1'b1;
      recv_data_i  <= b;
      @(posedge clk_i);
      recv_valid_i <= 1'b0;
      if (fifo_model.size() < RX_FIFO_DEPTH)
         fifo_model.push_back(b);
      else
         m_ovf = 1'b1;   // byte lost
   endtask

   task automatic pop_check();
      read_check(REG_RDR);
      read_check(REG_STA);
      bus_write(REG_STA, 32'h1 << STA_RX_AVAIL, 4'h1);
   endtask

   task automatic strobe_audio(input sample_t l, input sample_t r);
      @(posedge clk_i);
      audio_en_i <= 1'b1;
      audio_li_i <= l;
      audio_ri_i <= r;
      @(posedge clk_i);
      audio_en_i <= 1'b0;
      m_audio = {l, r};
      m_flag  = 1'b1;
   endtask

   task automatic wait_key(input int n);
      int t;
      t = 0;
      while (key_count < n && t < 16) begin
         @(negedge clk_i);
         t++;
      end
      repeat (4) @(negedge clk_i);   // room for a stray second pulse
      if (key_count != n)
         note_error($sformatf("expected %0d keyboard requests, saw %0d", n, key_count));
      else
         check("key_value_o", {16'd0, key_last}, {16'd0, m_tdr[15:0]});
      m_busy = 1'b0;
      read_check(REG_STA);
   endtask

   initial begin
      int        codes[8];
      int        j;
      int        tmp;
      int        n;
      bus_data_t d;
      logic [3:0] be;
      void'($urandom(32'h1450));
      rst_i        = 1'b1;
      write_i      = 1'b0;
      be_i         = '0;
      addr_i       = '0;
      wdata_i      = '0;
      pad_audio_i  = 4'($urandom);   // nonzero pads must stay off the pins after reset
      pad_key_i    = 4'($urandom);
      pad_serial_i = 4'($urandom);
      recv_data_i  = '0;
      recv_valid_i = 1'b0;
      send_ready_i = 1'b0;
      audio_en_i   = 1'b0;
      audio_li_i   = '0;
      audio_ri_i   = '0;
      repeat (16) @(posedge clk_i);
      rst_i <= 1'b0;
      @(negedge clk_i);
      check("audio/key/serial_rst_o", {29'd0, audio_rst_o, key_rst_o, serial_rst_o}, 32'h7);
      check("usb pads dn/dp/oe/pull",
            {28'd0, usb_dn_tx_o, usb_dp_tx_o, usb_oe_o, usb_dp_pull_o}, 0);
      check("send_valid_o/key_request_o", {30'd0, send_valid_o, key_request_o}, 0);
      read_check(REG_CCR);
      read_check(REG_RDR);
      read_check(REG_TDR);
      read_check(REG_STA);

      // every code once in shuffled order
      for (int i = 0; i < 8; i++)
         codes[i] = i;
      for (int i = 7; i > 0; i--) begin
         j        = $urandom % (i + 1);
         tmp      = codes[i];
         codes[i] = codes[j];
         codes[j] = tmp;
      end
      foreach (codes[i])
         select_func(codes[i]);

      // serial transmit with back-pressure
      select_func(5);
      d = $urandom;
      bus_write(REG_TDR, d, 4'hf);
      @(negedge clk_i);
      check("send_valid_o", {31'd0, send_valid_o}, 32'd1);
      check("send_data_o", {24'd0, send_data_o}, {24'd0, m_tdr[7:0]});
      bus_write(REG_TDR, ~d, 4'hf);   // TDR still busy so this write is dropped
      n = 1 + $urandom % 6;
      repeat (n) read_check(REG_STA);
      read_check(REG_TDR);
      @(posedge clk_i);
      send_ready_i <= 1'b1;
      n = 0;
      while (sent_q.size() == 0 && n < 16) begin
         @(negedge clk_i);
         n++;
      end
      @(posedge clk_i);
      send_ready_i <= 1'b0;
      m_busy = 1'b0;
      check("serial bytes sent", 32'(sent_q.size()), 32'd1);
      if (sent_q.size() != 0)
         check("send_data_o", {24'd0, sent_q.pop_front()}, {24'd0, d[7:0]});
      read_check(REG_STA);
      check("send_valid_o", {31'd0, send_valid_o}, 32'd0);

      // serial receive followed by overflow
      repeat (3) push_byte(8'($urandom));
      while (fifo_model.size() != 0)
         pop_check();
      read_check(REG_RDR);
      read_check(REG_STA);
      repeat (RX_FIFO_DEPTH + 1) push_byte(8'($urandom));
      read_check(REG_STA);
      while (fifo_model.size() != 0)
         pop_check();
      read_check(REG_RDR);
      read_check(REG_STA);
      bus_write(REG_STA, 32'h1 << STA_RX_OVF, 4'h1);
      read_check(REG_STA);

      // audio capture and playback
      select_func(1);
      repeat (3) begin
         strobe_audio(16'($urandom), 16'($urandom));
         read_check(REG_RDR);
         read_check(REG_STA);
         bus_write(REG_STA, 32'h1 << STA_RX_AVAIL, 4'h1);
         read_check(REG_STA);
      end
      bus_write(REG_TDR, $urandom, 4'hf);
      @(negedge clk_i);
      check("audio_lo_o", {16'd0, audio_lo_o}, {16'd0, m_tdr[31:16]});
      check("audio_ro_o", {16'd0, audio_ro_o}, {16'd0, m_tdr[15:0]});
      read_check(REG_STA);

      // keyboard with a full and then a partial TDR write
      select_func(4);
      bus_write(REG_TDR, $urandom, 4'hf);
      wait_key(1);
      be = 4'($urandom % 14 + 1);   // at least one byte left out
      bus_write(REG_TDR, $urandom, be);
      read_check(REG_TDR);
      wait_key(2);

      repeat (4) @(posedge clk_i);
      $display("checks %0d, value errors %0d, other errors %0d",
               n_checks, n_val_err, n_other_err);
      if (n_val_err + n_other_err == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/usb_bridge_pkg.sv
design/usb_rx_fifo.sv
design/usb_func_ctrl.sv
design/usb_reg_bank.sv
design/usb_bridge_top.sv
bench/usb_bridge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= usb_bridge_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJ_DIR)/$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
